// ==== Bender.yml ====
package:
  name: shim_dac_ctrl

sources:
  - files:
      - verilog/dac_cmd_pkg.sv
      - verilog/dac_spi_pkg.sv
      - verilog/dac_ifs.sv
      - verilog/dac_cmd_decode.sv
      - verilog/dac_sequencer.sv
      - verilog/dac_cal_pipe.sv
      - verilog/dac_spi_tx.sv
      - verilog/shim_dac_ctrl.sv
  - target: test
    files:
      - tb/tb_shim_dac_ctrl.sv

// ==== shim_dac_ctrl.f ====
verilog/dac_cmd_pkg.sv
verilog/dac_spi_pkg.sv
verilog/dac_ifs.sv
verilog/dac_cmd_decode.sv
verilog/dac_sequencer.sv
verilog/dac_cal_pipe.sv
verilog/dac_spi_tx.sv
verilog/shim_dac_ctrl.sv
tb/tb_shim_dac_ctrl.sv

// ==== tb/tb_shim_dac_ctrl.sv ====
module tb_shim_dac_ctrl;
  import dac_spi_pkg::*;

  localparam int N_WR      = 4;                         // Write commands over the whole run
  localparam int DELAY_SUM = 2000 + 2000 + 5000 + 10;   // Delay counts used by the tests
  localparam int RUN_CYC   = 2 * (N_WR * 8 * (N_CS_HIGH + 24) + DELAY_SUM);

  logic        clk;
  logic        resetn;
  logic [31:0] cmd_word;
  logic        cmd_buf_empty;
  logic        trigger;
  wire         cmd_word_rd_en, waiting_for_trig, n_cs, mosi, ldac;
  wire         cmd_buf_underflow, unexp_trig, delay_too_short, cal_oob, dac_val_oob;
  wire         err_any;

  logic [31:0] cmd_q [$];  // Show-ahead command buffer contents
  logic [23:0] exp_q [$];  // Frames still expected on the SPI bus
  logic [15:0] lfsr;
  int          cal_tab [8];
  logic [23:0] mon_sh, frame_got, frame_exp;
  int          mon_bits, nframes, ldac_cnt, ldac_base;
  logic        frame_vld, frames_on, expect_clean;
  logic        chk_stb;
  int          chk_got, chk_exp, checks, err_cnt;
  string       chk_what;

  shim_dac_ctrl shim_dac_ctrl_i (
    .clk (clk), .resetn (resetn), .cmd_word (cmd_word), .cmd_buf_empty (cmd_buf_empty),
    .cmd_word_rd_en (cmd_word_rd_en), .trigger (trigger), .waiting_for_trig (waiting_for_trig),
    .n_cs (n_cs), .mosi (mosi), .ldac (ldac), .cmd_buf_underflow (cmd_buf_underflow),
    .unexp_trig (unexp_trig), .delay_too_short (delay_too_short), .cal_oob (cal_oob),
    .dac_val_oob (dac_val_oob)
  );

  assign err_any = cmd_buf_underflow | unexp_trig | delay_too_short | cal_oob | dac_val_oob;

  always #20 clk = ~clk; // 40 unit period

  ////////////////////////////////////////////////////////////////////////////
  // Buffer model, SPI monitor, ldac counter
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (cmd_word_rd_en && cmd_q.size() != 0) void'(cmd_q.pop_front()); // Consume head word
    cmd_word      <= (cmd_q.size() != 0) ? cmd_q[0] : 32'h0;
    cmd_buf_empty <= (cmd_q.size() == 0);
  end

  always @(posedge clk) begin
    frame_vld <= 1'b0;
    if (!resetn || n_cs) begin
      mon_bits <= 0; // Partial frames are dropped
    end else begin
      mon_sh <= {mon_sh[22:0], mosi};
      if (mon_bits == 23) begin
        mon_bits <= 0;
        if (frames_on) begin
          frame_vld <= 1'b1;
          frame_got <= {mon_sh[22:0], mosi};
          nframes   <= nframes + 1;
          if (exp_q.size() != 0) frame_exp <= exp_q.pop_front();
          else frame_exp <= ~{mon_sh[22:0], mosi}; // Extra frame forces a mismatch
        end
      end else begin
        mon_bits <= mon_bits + 1;
      end
    end
  end

  always @(posedge clk) begin
    if (!resetn) ldac_cnt <= 0;
    else if (ldac) ldac_cnt <= ldac_cnt + 1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  a_frame: assert property (@(posedge clk) disable iff (!resetn)
    frame_vld |-> frame_got == frame_exp)
    else begin
      $display("error %0t: frame %h, expected %h", $time, frame_got, frame_exp);
      err_cnt++;
    end
  a_check: assert property (@(posedge clk) chk_stb |-> chk_got == chk_exp)
    else begin
      $display("error %0t: %s is %0d, expected %0d", $time, chk_what, chk_got, chk_exp);
      err_cnt++;
    end
  a_clean: assert property (@(posedge clk) disable iff (!resetn) expect_clean |-> !err_any)
    else begin
      $display("error %0t: error flag raised in a clean test", $time);
      err_cnt++;
    end
  // HALT keeps chip select high and the buffer untouched
  a_halt: assert property (@(posedge clk) disable iff (!resetn)
    err_any |=> n_cs && !cmd_word_rd_en)
    else begin
      $display("error %0t: activity on the bus after an error", $time);
      err_cnt++;
    end
  a_rd: assert property (@(posedge clk) disable iff (!resetn) cmd_word_rd_en |-> !cmd_buf_empty)
    else begin
      $display("error %0t: read from an empty buffer", $time);
      err_cnt++;
    end
  // No words leave the buffer while reset is held
  a_rst_rd: assert property (@(posedge clk) !resetn |-> !cmd_word_rd_en)
    else begin
      $display("error %0t: read from the buffer during reset", $time);
      err_cnt++;
    end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // 16-bit Fibonacci LFSR stepped once per bit and kept clear of the range edges
  function automatic logic [15:0] draw_val();
    logic [15:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < 16; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[14:0], fb};
    end
    if (v == 16'hFFFF) v = 16'hFFFE;
    return 16'(4096 + v % 57000);
  endfunction

  task automatic push_cmd(input logic [31:0] w);
    @(negedge clk);
    cmd_q.push_back(w);
  endtask

  task automatic set_cal(input int ch, input int val);
    push_cmd({2'b10, 11'b0, 3'(ch), 16'(val)});
    if (val <= 4096 && val >= -4096) cal_tab[ch] = val;
  endtask

  // Write command plus four pair words with the even channel in the low half
  task automatic send_write(input bit ldac_f, input int delay, input bit bad_pair);
    logic [15:0] v [8];
    for (int i = 0; i < 8; i++) v[i] = draw_val();
    if (bad_pair) v[3] = 16'hFFFF;
    push_cmd({2'b01, ldac_f, 3'b000, 26'(delay)});
    for (int p = 0; p < 4; p++) push_cmd({v[2*p+1], v[2*p]});
    for (int i = 0; i < 8; i++) exp_q.push_back({4'b0001, 1'b0, 3'(i), 16'(v[i] + cal_tab[i])});
  endtask

  task automatic pulse_trigger();
    @(posedge clk) trigger <= 1'b1;
    @(posedge clk) trigger <= 1'b0;
  endtask

  task automatic apply_reset();
    @(posedge clk) resetn <= 1'b0;
    trigger <= 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    cmd_q.delete();
    exp_q.delete();
    for (int i = 0; i < 8; i++) cal_tab[i] = 0;
    @(posedge clk) resetn <= 1'b1;
  endtask

  // Event codes are 0 for ldac, 1 for waiting_for_trig and 2 for any error flag
  task automatic wait_until(input int what, input int limit, input string name);
    int n;
    bit hit;
    n   = 0;
    hit = 0;
    while (!hit && n < limit) begin
      @(posedge clk);
      n++;
      case (what)
        0:       hit = ldac;
        1:       hit = waiting_for_trig;
        default: hit = err_any;
      endcase
    end
    if (!hit) begin
      $display("timeout after %0d cycles waiting for %s", limit, name);
      err_cnt++;
    end
  endtask

  task automatic check_eq(input int got, input int exp, input string what);
    @(posedge clk);
    chk_got  <= got;
    chk_exp  <= exp;
    chk_what <= what;
    chk_stb  <= 1'b1;
    checks++;
    @(posedge clk) chk_stb <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk           = 0;
    resetn        = 0;
    trigger       = 0;
    cmd_word      = '0;
    cmd_buf_empty = 1;
    lfsr          = 16'd54;
    mon_sh        = '0;
    mon_bits      = 0;
    nframes       = 0;
    frame_vld     = 0;
    frame_got     = '0;
    frame_exp     = '0;
    chk_stb       = 0;
    checks        = 0;
    err_cnt       = 0;
    frames_on     = 1;
    expect_clean  = 1;
    apply_reset();

    send_write(1'b1, 2000, 1'b0);                 // Zero calibration
    wait_until(0, 3000, "ldac of the first write");
    repeat (5) @(posedge clk);
    check_eq(exp_q.size(), 0, "frames missing");
    check_eq(nframes, 8, "frame count");
    check_eq(ldac_cnt, 1, "ldac pulses");
    $display("test 1 plain write finished, %0d errors", err_cnt);

    set_cal(0, 3000);
    set_cal(1, -4096);
    set_cal(5, 4096);
    set_cal(6, -1234);
    send_write(1'b1, 2000, 1'b0);
    wait_until(0, 3000, "ldac of the calibrated write");
    repeat (5) @(posedge clk);
    check_eq(exp_q.size(), 0, "frames missing");
    check_eq(ldac_cnt, 2, "ldac pulses");
    $display("test 2 calibrated write finished, %0d errors", err_cnt);

    frames_on = 0;
    ldac_base = ldac_cnt;
    push_cmd({2'b00, 1'b1, 1'b1, 2'b00, 26'd3}); // No-op waiting for 3 triggers
    wait_until(1, 50, "trigger wait");
    pulse_trigger();
    pulse_trigger();
    repeat (3) @(posedge clk);
    check_eq(waiting_for_trig, 1, "waiting_for_trig after two triggers");
    check_eq(ldac_cnt - ldac_base, 0, "early ldac pulses");
    pulse_trigger();
    wait_until(0, 20, "ldac after third trigger");
    repeat (3) @(posedge clk);
    check_eq(waiting_for_trig, 0, "waiting_for_trig after third trigger");
    push_cmd({2'b00, 1'b1, 2'b00, 1'b0, 26'd5000}); // Long delay that a cancel cuts short
    repeat (20) @(posedge clk);
    push_cmd(32'hC000_0000);
    repeat (20) @(posedge clk);
    check_eq(cmd_q.size(), 0, "words left after cancel");
    check_eq(ldac_cnt - ldac_base, 1, "ldac pulses with cancel");
    $display("test 3 trigger wait and cancel finished, %0d errors", err_cnt);

    expect_clean = 0;
    apply_reset();
    pulse_trigger();                              // Trigger while idle
    wait_until(2, 10, "unexp_trig");
    check_eq(unexp_trig, 1, "unexp_trig");
    push_cmd(32'h0000_0010);
    repeat (20) @(posedge clk);
    check_eq(cmd_q.size(), 1, "words left in halt");
    check_eq(n_cs, 1, "n_cs in halt");
    apply_reset();
    send_write(1'b0, 10, 1'b0);
    wait_until(2, 500, "delay_too_short");
    check_eq(delay_too_short, 1, "delay_too_short");
    repeat (20) @(posedge clk);
    check_eq(n_cs, 1, "n_cs in halt");
    $display("test 4 trigger and delay errors finished, %0d errors", err_cnt);

    apply_reset();
    set_cal(2, 5000);
    wait_until(2, 20, "cal_oob");
    check_eq(cal_oob, 1, "cal_oob");
    apply_reset();
    send_write(1'b0, 2000, 1'b1);
    wait_until(2, 100, "dac_val_oob");
    check_eq(dac_val_oob, 1, "dac_val_oob");
    apply_reset();
    push_cmd({2'b00, 2'b00, 1'b1, 1'b0, 26'd5}); // Continuation with nothing behind it
    wait_until(2, 50, "cmd_buf_underflow");
    check_eq(cmd_buf_underflow, 1, "cmd_buf_underflow");
    $display("test 5 bound and underflow errors finished, %0d errors", err_cnt);

    $display("5 tests, %0d checks, %0d frames, %0d errors", checks, nframes, err_cnt);
    if (err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Watchdog at twice the expected run length
  initial begin
    #(RUN_CYC * 40);
    $display("watchdog expired after %0d cycles, run did not finish", RUN_CYC);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== verilog/dac_cal_pipe.sv ====
module dac_cal_pipe (
  input  logic    clk,
  input  logic    resetn,
  dac_pair_if.cal pair,
  output logic    cal_sum_oob // Calibrated value left the DAC range
);
  import dac_cmd_pkg::*;
  import dac_spi_pkg::*;

  typedef logic signed [$bits(dac_signed_t):0] sum_t; // One spare bit over value + cal

  cal_t cal_tab [NUM_CH];
  ch_t  ch_odd;
  ch_t  ch_s1;    // Base channel held for stage two
  sum_t sum_lo;
  sum_t sum_hi;
  logic v1;       // Stage one holds a pair

  function automatic logic in_range(sum_t s);
    return (s >= -OFFSET_ZERO) && (s <= OFFSET_ZERO);
  endfunction

  // Back to offset code, zero output when out of range
  function automatic dac_val_t to_offset(sum_t s);
    return in_range(s) ? dac_val_t'(s + OFFSET_ZERO) : dac_val_t'(OFFSET_ZERO);
  endfunction

  function automatic frame_t make_frame(ch_t ch, dac_val_t val);
    return {SPI_REG_WRITE, 1'b0, ch, val};
  endfunction

  assign ch_odd = pair.ch + ch_t'(1);

  // Calibration table, kept through a halt
  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 0; i < NUM_CH; i++) cal_tab[i] <= '0;
    end else if (pair.cal_wr) begin
      cal_tab[pair.cal_ch] <= pair.cal_val;
    end
  end

  // Stage one, add calibration
  always_ff @(posedge clk) begin
    if (pair.req) begin
      sum_lo <= sum_t'(pair.val_lo) + sum_t'(cal_tab[pair.ch]);
      sum_hi <= sum_t'(pair.val_hi) + sum_t'(cal_tab[ch_odd]);
      ch_s1  <= pair.ch;
    end
  end

  // Stage two, range check and frame build
  always_ff @(posedge clk) begin
    if (v1) begin
      pair.frame_hi <= make_frame(ch_s1, to_offset(sum_lo));             // Even channel first
      pair.frame_lo <= make_frame(ch_s1 + ch_t'(1), to_offset(sum_hi));
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      v1          <= 1'b0;
      pair.load   <= 1'b0;
      cal_sum_oob <= 1'b0;
    end else begin
      v1          <= pair.req;
      pair.load   <= v1;        // req + 2
      cal_sum_oob <= v1 && !(in_range(sum_lo) && in_range(sum_hi));
    end
  end

endmodule

// ==== verilog/dac_cmd_decode.sv ====
module dac_cmd_decode #(
  parameter int abs_cal_max = 4096 // Largest |calibration| accepted
) (
  input  logic [31:0] cmd_word,      // Head of the show-ahead buffer
  input  logic        cmd_buf_empty,
  dac_cmd_if.decode   cmd
);
  import dac_cmd_pkg::*;
  import dac_spi_pkg::*;

  localparam int CH_W = $bits(ch_t);

  cal_t     cal_word;
  dac_val_t raw_lo;
  dac_val_t raw_hi;

  // 0 maps to -32767, 32767 to 0; 0xFFFF is flagged separately
  function automatic dac_signed_t offset_to_signed(dac_val_t raw);
    return dac_signed_t'($signed({1'b0, raw}) - OFFSET_ZERO);
  endfunction

  assign raw_lo   = cmd_word[15:0];  // Even channel in low half
  assign raw_hi   = cmd_word[31:16];
  assign cal_word = cmd_word[CAL_VAL_W-1:0];

  // Command fields, meaningful only when present
  assign cmd.present = !cmd_buf_empty;
  assign cmd.kind    = cmd_kind_e'(cmd_word[31:30]);
  assign cmd.ldac    = cmd_word[CMD_LDAC_BIT];
  assign cmd.trig    = cmd_word[CMD_TRIG_BIT];
  assign cmd.cont    = cmd_word[CMD_CONT_BIT];
  assign cmd.count   = cmd_word[CMD_COUNT_W-1:0];

  // Set-calibration fields and the symmetric bound
  assign cmd.cal_ch       = cmd_word[CAL_CH_LSB +: CH_W];
  assign cmd.cal_val      = cal_word;
  assign cmd.cal_in_range = (cal_word <= abs_cal_max) && (cal_word >= -abs_cal_max);

  // Value-pair view of the same word
  assign cmd.val_lo       = offset_to_signed(raw_lo);
  assign cmd.val_hi       = offset_to_signed(raw_hi);
  assign cmd.val_reserved = (raw_lo == VAL_RESERVED) || (raw_hi == VAL_RESERVED);

endmodule

// ==== verilog/dac_cmd_pkg.sv ====
package dac_cmd_pkg;

  // Opcode, bits 31..30 of every command word
  typedef enum logic [1:0] {
    NO_OP   = 2'b00, // Delay or trigger wait only
    DAC_WR  = 2'b01, // Four value-pair words follow
    SET_CAL = 2'b10, // Load one calibration entry
    CANCEL  = 2'b11  // Ends a pending wait early
  } cmd_kind_e;

  // Flag bits of NO_OP and DAC_WR words
  localparam int CMD_LDAC_BIT = 29; // Pulse ldac when the command ends
  localparam int CMD_TRIG_BIT = 28; // Count is triggers, not cycles
  localparam int CMD_CONT_BIT = 27; // Another command must follow at once

  localparam int CMD_COUNT_W = 26;
  typedef logic [CMD_COUNT_W-1:0] cmd_count_t; // Delay cycles or trigger count

  // SET_CAL layout, channel above the value
  localparam int CAL_CH_LSB = 16;
  localparam int CAL_VAL_W  = 16;
  typedef logic signed [CAL_VAL_W-1:0] cal_t;

  typedef enum logic [2:0] {
    S_IDLE,      // Waiting for a command word
    S_DELAY,     // Delay timer running
    S_TRIG_WAIT, // Counting external triggers
    S_DAC_WR,    // Pairs going out over SPI
    S_HALT       // Error seen, only reset leaves
  } seq_state_e;

  typedef struct packed {
    logic cmd_buf_underflow;
    logic unexp_trig;
    logic delay_too_short;
    logic cal_oob;
    logic dac_val_oob;
  } err_flags_t;

endpackage

// ==== verilog/dac_ifs.sv ====
// Decoded view of the head command word
interface dac_cmd_if;
  import dac_cmd_pkg::*;
  import dac_spi_pkg::*;

  logic        present;      // Head word is valid
  cmd_kind_e   kind;
  logic        ldac;
  logic        trig;
  logic        cont;
  cmd_count_t  count;
  ch_t         cal_ch;
  cal_t        cal_val;
  logic        cal_in_range;
  dac_signed_t val_lo;       // Even channel of a pair
  dac_signed_t val_hi;       // Odd channel of a pair
  logic        val_reserved; // Either half is 0xFFFF

  modport decode (output present, kind, ldac, trig, cont, count, cal_ch, cal_val,
                  cal_in_range, val_lo, val_hi, val_reserved);
  modport sequencer (input present, kind, ldac, trig, cont, count, cal_ch, cal_val,
                     cal_in_range, val_lo, val_hi, val_reserved);
endinterface

// Pair path from sequencer through calibration to the SPI shifter
interface dac_pair_if;
  import dac_cmd_pkg::*;
  import dac_spi_pkg::*;

  logic        req;       // One-cycle strobe per value pair
  ch_t         ch;        // Even base channel
  dac_signed_t val_lo;
  dac_signed_t val_hi;
  logic        cal_wr;    // Calibration table write strobe
  ch_t         cal_ch;
  cal_t        cal_val;
  logic        load;      // Frames valid, two cycles after req
  frame_t      frame_hi;  // Sent first, carries channel ch
  frame_t      frame_lo;  // Sent second, carries ch + 1
  logic        pair_done; // Strobe as n_cs rises after frame_lo

  modport sequencer (output req, ch, val_lo, val_hi, cal_wr, cal_ch, cal_val,
                     input pair_done);
  modport cal (input req, ch, val_lo, val_hi, cal_wr, cal_ch, cal_val,
               output load, frame_hi, frame_lo);
  modport spi (input load, frame_hi, frame_lo, output pair_done);
endinterface

// ==== verilog/dac_sequencer.sv ====
module dac_sequencer (
  input  logic                     clk,
  input  logic                     resetn,
  dac_cmd_if.sequencer             cmd,
  dac_pair_if.sequencer            pair,
  input  logic                     trigger,          // Single-cycle strobe
  input  logic                     cal_sum_oob,      // From stage two of the cal pipe
  output logic                     cmd_word_rd_en,   // Pops the head word
  output logic                     waiting_for_trig,
  output logic                     ldac,
  output dac_cmd_pkg::err_flags_t  errors            // Sticky until reset
);
  import dac_cmd_pkg::*;
  import dac_spi_pkg::*;

  localparam ch_t LAST_PAIR_CH = ch_t'(NUM_CH - 2);

  seq_state_e state;
  seq_state_e head_state;  // Where the head command would send us
  logic       do_ldac;     // Latched command flags
  logic       wait_trig;
  logic       expect_next;
  logic       pair_pend;   // A value-pair word is due from the buffer
  ch_t        pair_ch;
  cmd_count_t delay_timer;
  cmd_count_t trig_cnt;
  logic       is_wait_cmd;
  logic       take;
  logic       cancel;
  logic       wait_end;
  logic       pair_pop;
  logic       wr_done;
  err_flags_t err_set;
  logic       err_now;

  ////////////////////////////////////////////////////////////////////////////
  // Command flow
  ////////////////////////////////////////////////////////////////////////////

  assign is_wait_cmd = (cmd.kind == NO_OP) || (cmd.kind == DAC_WR); // These carry flags
  assign cancel      = cmd.present && (cmd.kind == CANCEL)
                       && ((state == S_DELAY) || (state == S_TRIG_WAIT));
  assign wait_end    = ((state == S_DELAY) && (delay_timer == '0))
                       || ((state == S_TRIG_WAIT) && trigger && (trig_cnt <= 1));
  // New command starts from idle or right at the end of a wait
  assign take        = cmd.present && ((state == S_IDLE) || (wait_end && !cancel));
  assign pair_pop    = (state == S_DAC_WR) && pair_pend && cmd.present;
  assign wr_done     = (state == S_DAC_WR) && pair.pair_done && (pair_ch == LAST_PAIR_CH);

  // Each term needs present, and nothing is popped while in reset
  assign cmd_word_rd_en   = resetn && (take || cancel || pair_pop);
  assign waiting_for_trig = (state == S_TRIG_WAIT);

  always_comb begin
    case (cmd.kind)
      NO_OP:   head_state = cmd.trig ? S_TRIG_WAIT : S_DELAY;
      DAC_WR:  head_state = S_DAC_WR;
      default: head_state = S_IDLE; // SET_CAL and CANCEL finish at once
    endcase
  end

  // Pair requests and calibration writes
  assign pair.req     = pair_pop && !cmd.val_reserved;
  assign pair.ch      = pair_ch;
  assign pair.val_lo  = cmd.val_lo;  // Sampled by the cal pipe on req
  assign pair.val_hi  = cmd.val_hi;
  assign pair.cal_wr  = take && (cmd.kind == SET_CAL) && cmd.cal_in_range;
  assign pair.cal_ch  = cmd.cal_ch;
  assign pair.cal_val = cmd.cal_val;

  ////////////////////////////////////////////////////////////////////////////
  // Error detection
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    err_set.cmd_buf_underflow = ((state == S_DAC_WR) && pair_pend && !cmd.present)
                                || (wait_end && !cancel && !cmd.present && expect_next);
    err_set.unexp_trig        = trigger && (state != S_TRIG_WAIT);
    // Timer ran out while pairs were still going out
    err_set.delay_too_short   = (state == S_DAC_WR) && !wait_trig
                                && (delay_timer == '0) && !wr_done;
    err_set.cal_oob           = take && (cmd.kind == SET_CAL) && !cmd.cal_in_range;
    err_set.dac_val_oob       = (pair_pop && cmd.val_reserved) || cal_sum_oob;
  end

  assign err_now = |err_set;

  ////////////////////////////////////////////////////////////////////////////
  // FSM, timers and pair index
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= S_IDLE;
    end else if (err_now) begin
      state <= S_HALT; // Parked until reset
    end else begin
      case (state)
        S_IDLE: begin
          if (take) state <= head_state;
        end
        S_DELAY, S_TRIG_WAIT: begin
          if (cancel) state <= S_IDLE;
          else if (wait_end) state <= cmd.present ? head_state : S_IDLE;
        end
        S_DAC_WR: begin
          if (wr_done) state <= wait_trig ? S_TRIG_WAIT : S_DELAY; // Finish with the wait
        end
        default: state <= S_HALT;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      do_ldac     <= 1'b0;
      wait_trig   <= 1'b0;
      expect_next <= 1'b0;
      pair_pend   <= 1'b0;
      pair_ch     <= '0;
      delay_timer <= '0;
      trig_cnt    <= '0;
      ldac        <= 1'b0;
      errors      <= '0;
    end else begin
      ldac   <= do_ldac && wait_end && !cancel && !err_now; // End of command
      errors <= errors | err_set;
      if (take) begin
        do_ldac     <= is_wait_cmd && cmd.ldac;
        wait_trig   <= is_wait_cmd && cmd.trig;
        expect_next <= is_wait_cmd && cmd.cont;
        delay_timer <= (is_wait_cmd && !cmd.trig) ? cmd.count : '0; // Runs during the write too
        trig_cnt    <= (is_wait_cmd && cmd.trig) ? cmd.count : '0;
        pair_pend   <= (cmd.kind == DAC_WR); // First pair is the next word
        pair_ch     <= '0;
      end else begin
        if (delay_timer != '0) delay_timer <= delay_timer - 1'b1;
        if ((state == S_TRIG_WAIT) && trigger && (trig_cnt != '0)) trig_cnt <= trig_cnt - 1'b1;
        if (pair_pop) begin
          pair_pend <= 1'b0;
        end else if ((state == S_DAC_WR) && pair.pair_done && !wr_done) begin
          pair_pend <= 1'b1;            // Next pair only after the last one left
          pair_ch   <= pair_ch + ch_t'(2);
        end
      end
    end
  end

endmodule

// ==== verilog/dac_spi_pkg.sv ====
package dac_spi_pkg;

  localparam int NUM_CH = 8;
  typedef logic [$clog2(NUM_CH)-1:0] ch_t;

  typedef logic [15:0]        dac_val_t;    // Offset code, 32767 is zero
  typedef logic signed [16:0] dac_signed_t; // Needs the extra bit for +32768

  // Frame is {cmd, 0, channel, value}, MSB first
  localparam logic [3:0] SPI_REG_WRITE = 4'b0001; // Write input register, wait for LDAC
  localparam int FRAME_W = 24;
  typedef logic [FRAME_W-1:0] frame_t;

  localparam int       OFFSET_ZERO  = 32767;
  localparam dac_val_t VAL_RESERVED = 16'hFFFF; // Never legal on the bus

  // Chip-select high time, one SPI bit per clk
  localparam int CLK_MHZ          = 20;
  localparam int T_UPDATE_NS      = 830; // Rising edge to rising edge of n_cs
  localparam int T_CS_HIGH_MIN_NS = 30;
  localparam int UPDATE_CYC       = (T_UPDATE_NS * CLK_MHZ + 999) / 1000;
  localparam int CS_MIN_CYC       = (T_CS_HIGH_MIN_NS * CLK_MHZ + 999) / 1000;
  localparam int CS_FLOOR_CYC     = (CS_MIN_CYC < 4) ? 4 : CS_MIN_CYC;
  // Whatever the update time leaves after 24 bits, clamped to 4..31
  localparam int N_CS_HIGH =
    (UPDATE_CYC - FRAME_W < CS_FLOOR_CYC) ? CS_FLOOR_CYC :
    (UPDATE_CYC - FRAME_W > 31)           ? 31 :
                                            UPDATE_CYC - FRAME_W;

endpackage

// ==== verilog/dac_spi_tx.sv ====
module dac_spi_tx (
  input  logic    clk,
  input  logic    resetn,
  input  logic    halt,  // Sequencer is in HALT
  dac_pair_if.spi pair,
  output logic    n_cs,
  output logic    mosi
);
  import dac_spi_pkg::*;

  localparam int CNT_W = 5;
  localparam logic [CNT_W-1:0] CS_HIGH_CYC = CNT_W'(N_CS_HIGH);
  localparam logic [CNT_W-1:0] FRAME_BITS  = CNT_W'(FRAME_W);

  logic [CNT_W-1:0]     cs_timer;  // High cycles left before n_cs falls
  logic [CNT_W-1:0]     bit_cnt;   // Bits left in the current frame
  logic                 second;    // frame_lo is the one going out
  logic [2*FRAME_W-1:0] shift_reg;

  assign mosi = shift_reg[2*FRAME_W-1]; // MSB first

  always_ff @(posedge clk) begin
    if (!resetn || halt) begin
      n_cs           <= 1'b1;
      cs_timer       <= '0;
      bit_cnt        <= '0;
      second         <= 1'b0;
      shift_reg      <= '0;
      pair.pair_done <= 1'b0;
    end else begin
      pair.pair_done <= 1'b0;
      if (pair.load) begin
        shift_reg <= {pair.frame_hi, pair.frame_lo};
        cs_timer  <= CS_HIGH_CYC;
        second    <= 1'b0;
      end else if (cs_timer != '0) begin
        cs_timer <= cs_timer - 1'b1;
        if (cs_timer == 1) begin
          n_cs    <= 1'b0;      // Open the frame window
          bit_cnt <= FRAME_BITS;
        end
      end else if (bit_cnt != '0) begin
        shift_reg <= {shift_reg[2*FRAME_W-2:0], 1'b0};
        bit_cnt   <= bit_cnt - 1'b1;
        if (bit_cnt == 1) begin
          n_cs <= 1'b1;         // Rising edge latches the frame in the DAC
          if (!second) begin
            second   <= 1'b1;
            cs_timer <= CS_HIGH_CYC;
          end else begin
            pair.pair_done <= 1'b1;
          end
        end
      end
    end
  end

endmodule

// ==== verilog/shim_dac_ctrl.sv ====
module shim_dac_ctrl #(
  parameter int abs_cal_max = 4096 // Calibration bound, used by the decoder
) (
  input  logic        clk,
  input  logic        resetn,
  input  logic [31:0] cmd_word,        // Show-ahead head word
  input  logic        cmd_buf_empty,
  output logic        cmd_word_rd_en,
  input  logic        trigger,
  output logic        waiting_for_trig,
  output logic        n_cs,
  output logic        mosi,
  output logic        ldac,
  output logic        cmd_buf_underflow,
  output logic        unexp_trig,
  output logic        delay_too_short,
  output logic        cal_oob,
  output logic        dac_val_oob
);
  import dac_cmd_pkg::*;

  err_flags_t errors;
  logic       cal_sum_oob;
  logic       halt;

  dac_cmd_if  cmd_bus ();
  dac_pair_if pair_bus ();

  ////////////////////////////////////////////////////////////////////////////
  // Decode, sequence, calibrate, shift out
  ////////////////////////////////////////////////////////////////////////////

  dac_cmd_decode #(
    .abs_cal_max (abs_cal_max)
  ) dac_cmd_decode_i (
    .cmd_word      (cmd_word),
    .cmd_buf_empty (cmd_buf_empty),
    .cmd           (cmd_bus)
  );

  dac_sequencer dac_sequencer_i (
    .clk              (clk),
    .resetn           (resetn),
    .cmd              (cmd_bus),
    .pair             (pair_bus),
    .trigger          (trigger),
    .cal_sum_oob      (cal_sum_oob),
    .cmd_word_rd_en   (cmd_word_rd_en),
    .waiting_for_trig (waiting_for_trig),
    .ldac             (ldac),
    .errors           (errors)
  );

  dac_cal_pipe dac_cal_pipe_i (
    .clk         (clk),
    .resetn      (resetn),
    .pair        (pair_bus),
    .cal_sum_oob (cal_sum_oob)
  );

  dac_spi_tx dac_spi_tx_i (
    .clk    (clk),
    .resetn (resetn),
    .halt   (halt),
    .pair   (pair_bus),
    .n_cs   (n_cs),
    .mosi   (mosi)
  );

  // Flags and HALT appear on the same edge
  assign halt = |errors;

  assign cmd_buf_underflow = errors.cmd_buf_underflow;
  assign unexp_trig        = errors.unexp_trig;
  assign delay_too_short   = errors.delay_too_short;
  assign cal_oob           = errors.cal_oob;
  assign dac_val_oob       = errors.dac_val_oob;

endmodule
